/* src/l1_cache_pkg.sv */
// **************************************************
// shared types for the L1 data cache
// bus request and response structs, the memory port
// mode and the FSM to frame array command word
// import into a module body as l1_cache_pkg::*
// **************************************************
package l1_cache_pkg;

    parameter int WORD_SIZE = 32;  // data and address width

    typedef logic [WORD_SIZE-1:0]   word_t;
    typedef logic [WORD_SIZE/8-1:0] byte_en_t;  // one bit per byte lane

    // processor side, held until busy drops
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;  // valid in the cycle busy is low
    } proc_rsp_t;

    // memory side, same shape as the processor bus
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } mem_req_t;

    typedef struct packed {
        logic  busy;   // beat accepted when low
        word_t rdata;
    } mem_rsp_t;

    // who owns the memory request this cycle
    typedef enum logic [2:0] {
        NONE,
        PASS,       // uncached access straight through
        FETCH,      // line refill reads
        WRITEBACK,  // victim line writes
        FLUSH_WB    // flush writes of the scanned set
    } port_mode_t;

    typedef struct packed {
        logic write_hit;    // merge request lanes, set dirty
        logic fill_word;    // store mem rdata at word_idx
        logic fill_done;    // set valid and tag
        logic clean_line;   // clear dirty after writeback
        logic flush_inval;  // drop valid and dirty at flush_set
    } array_cmd_t;

endpackage

/* src/block_counter.sv */
// **************************************************
// clearable up-counter with terminal flag
// counts words in a line and sets during a flush;
// done holds while count sits at LIMIT
// **************************************************
`timescale 1ns/100ps

module block_counter #(
    parameter int LIMIT = 2
) (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         clear,
    input  logic                         enable,
    output logic [$clog2(LIMIT+1)-1:0]   count,
    output logic                         done
);
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (clear) begin  // clear wins over enable
            count <= '0;
        end else if (enable) begin
            count <= count + 1'b1;
        end
    end

    assign done = (count == ($clog2(LIMIT+1))'(LIMIT));

endmodule

/* src/cache_frame_array.sv */
// **************************************************
// direct mapped line storage
// holds data, tag, valid and dirty per set; gives hit
// and victim status for the request address and line
// status for the set under flush; updates follow the
// command word from the control FSM
// **************************************************
`timescale 1ns/100ps

module cache_frame_array #(
    parameter int                  CACHE_SIZE          = 256,
    parameter int                  BLOCK_SIZE          = 2,
    parameter l1_cache_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000,
    localparam int N_SETS   = CACHE_SIZE / (BLOCK_SIZE * l1_cache_pkg::WORD_SIZE / 8),
    localparam int SET_BITS = $clog2(N_SETS),
    localparam int BLK_BITS = $clog2(BLOCK_SIZE),
    localparam int TAG_BITS = l1_cache_pkg::WORD_SIZE - SET_BITS - BLK_BITS - 2,
    localparam int WCNT_W   = $clog2(BLOCK_SIZE + 1),
    localparam int SCNT_W   = $clog2(N_SETS + 1)
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  l1_cache_pkg::proc_req_t  proc_req,
    input  l1_cache_pkg::word_t      mem_rdata,
    input  l1_cache_pkg::array_cmd_t array_cmd,
    input  logic [WCNT_W-1:0]        word_idx,
    input  logic [SCNT_W-1:0]        flush_set,
    output logic                     hit,
    output logic                     pass_through,
    output logic                     victim_dirty,
    output logic [TAG_BITS-1:0]      victim_tag,
    output l1_cache_pkg::word_t      hit_rdata,
    output logic                     flush_valid,
    output logic                     flush_dirty,
    output logic [TAG_BITS-1:0]      flush_tag,
    output l1_cache_pkg::word_t      line_rdata
);
    import l1_cache_pkg::*;

    word_t               data_q [N_SETS][BLOCK_SIZE];
    logic [TAG_BITS-1:0] tag_q  [N_SETS];
    logic [N_SETS-1:0]   valid_q, dirty_q;

    // request address fields
    logic [TAG_BITS-1:0] req_tag;
    logic [SET_BITS-1:0] req_set, fset, line_set;
    logic [BLK_BITS-1:0] req_word, cnt_word;

    assign req_tag  = proc_req.addr[WORD_SIZE-1 -: TAG_BITS];
    assign req_set  = proc_req.addr[2+BLK_BITS +: SET_BITS];
    assign req_word = proc_req.addr[2 +: BLK_BITS];
    assign fset     = flush_set[SET_BITS-1:0];   // counter runs one past the last set
    assign cnt_word = word_idx[BLK_BITS-1:0];

    // lookup
    assign pass_through = (proc_req.addr >= NONCACHE_START_ADDR);
    assign hit          = !pass_through && valid_q[req_set] && (tag_q[req_set] == req_tag);
    assign victim_dirty = valid_q[req_set] && dirty_q[req_set];
    assign victim_tag   = tag_q[req_set];
    assign hit_rdata    = data_q[req_set][req_word];

    // flush side status
    assign flush_valid = valid_q[fset];
    assign flush_dirty = dirty_q[fset];
    assign flush_tag   = tag_q[fset];

    // a flush only starts with no request on the bus
    assign line_set   = (proc_req.ren || proc_req.wen) ? req_set : fset;
    assign line_rdata = data_q[line_set][cnt_word];

    // data and tags
    always_ff @(posedge CLK) begin
        if (array_cmd.write_hit) begin
            for (int b = 0; b < WORD_SIZE/8; b++) begin
                if (proc_req.byte_en[b]) begin
                    data_q[req_set][req_word][8*b +: 8] <= proc_req.wdata[8*b +: 8];
                end
            end
        end
        if (array_cmd.fill_word) begin
            data_q[req_set][cnt_word] <= mem_rdata;  // refill word by word
        end
        if (array_cmd.fill_done) begin
            tag_q[req_set] <= req_tag;
        end
    end

    // line state bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (array_cmd.write_hit) begin
                dirty_q[req_set] <= 1'b1;
            end
            if (array_cmd.fill_done) begin
                valid_q[req_set] <= 1'b1;
            end
            if (array_cmd.clean_line) begin
                dirty_q[req_set] <= 1'b0;  // victim now in memory
            end
            if (array_cmd.flush_inval) begin
                valid_q[fset] <= 1'b0;
                dirty_q[fset] <= 1'b0;
            end
        end
    end

endmodule

/* src/mem_access_port.sv */
// **************************************************
// memory request and processor response steering
// keeps the line base for refill and writeback beats,
// builds beat addresses from base plus word count and
// passes uncached accesses through with lanes masked
// **************************************************
`timescale 1ns/100ps

module mem_access_port #(
    parameter int CACHE_SIZE = 256,
    parameter int BLOCK_SIZE = 2,
    localparam int N_SETS    = CACHE_SIZE / (BLOCK_SIZE * l1_cache_pkg::WORD_SIZE / 8),
    localparam int SET_BITS  = $clog2(N_SETS),
    localparam int BLK_BITS  = $clog2(BLOCK_SIZE),
    localparam int TAG_BITS  = l1_cache_pkg::WORD_SIZE - SET_BITS - BLK_BITS - 2,
    localparam int LINE_BITS = TAG_BITS + SET_BITS,
    localparam int WCNT_W    = $clog2(BLOCK_SIZE + 1),
    localparam int SCNT_W    = $clog2(N_SETS + 1)
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  l1_cache_pkg::proc_req_t  proc_req,
    input  l1_cache_pkg::port_mode_t port_mode,
    input  logic                     capture,
    input  logic                     victim_dirty,
    input  logic [TAG_BITS-1:0]      victim_tag,
    input  logic [TAG_BITS-1:0]      flush_tag,
    input  logic [SCNT_W-1:0]        flush_set,
    input  logic [WCNT_W-1:0]        word_idx,
    input  l1_cache_pkg::word_t      line_rdata,
    input  l1_cache_pkg::word_t      hit_rdata,
    input  logic                     hit,
    input  logic                     busy,
    input  l1_cache_pkg::mem_rsp_t   mem_rsp,
    output l1_cache_pkg::mem_req_t   mem_req,
    output l1_cache_pkg::proc_rsp_t  proc_rsp
);
    import l1_cache_pkg::*;

    logic [LINE_BITS-1:0] base_line;  // tag and set of the line being moved
    logic [BLK_BITS-1:0]  blk;
    logic                 beat_live;
    word_t                pass_wdata;

    // victim line first on a dirty miss, request line otherwise
    // and always once the writeback is through
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            base_line <= '0;
        end else if (capture) begin
            if (victim_dirty && !hit && port_mode == NONE) begin
                base_line <= {victim_tag, proc_req.addr[2+BLK_BITS +: SET_BITS]};
            end else begin
                base_line <= proc_req.addr[WORD_SIZE-1 -: LINE_BITS];
            end
        end
    end

    assign blk       = word_idx[BLK_BITS-1:0];
    assign beat_live = (word_idx != WCNT_W'(BLOCK_SIZE));  // quiet on the closing cycle

    // uncached writes carry zeros in disabled lanes
    always_comb begin
        for (int b = 0; b < WORD_SIZE/8; b++) begin
            pass_wdata[8*b +: 8] = proc_req.byte_en[b] ? proc_req.wdata[8*b +: 8] : 8'h00;
        end
    end

    always_comb begin
        mem_req         = '0;
        mem_req.addr    = {base_line, blk, 2'b00};
        mem_req.wdata   = line_rdata;
        mem_req.byte_en = '1;  // line beats move whole words
        case (port_mode)
            PASS: begin
                mem_req.ren     = proc_req.ren;
                mem_req.wen     = proc_req.wen;
                mem_req.addr    = proc_req.addr;
                mem_req.wdata   = pass_wdata;
                mem_req.byte_en = proc_req.byte_en;
            end
            FETCH:     mem_req.ren = beat_live;
            WRITEBACK: mem_req.wen = beat_live;
            FLUSH_WB: begin
                mem_req.wen  = beat_live;
                mem_req.addr = {flush_tag, flush_set[SET_BITS-1:0], blk, 2'b00};
            end
            default: mem_req.ren = 1'b0;
        endcase
    end

    assign proc_rsp.busy  = busy;
    assign proc_rsp.rdata = hit ? hit_rdata : mem_rsp.rdata;  // memory word on pass-through

endmodule

/* src/cache_ctrl_fsm.sv */
// **************************************************
// cache control FSM
// sequences hits, refills, victim writeback, uncached
// pass-through and the per-line flush walk; counters
// only advance on beats memory accepts
// **************************************************
`timescale 1ns/100ps

module cache_ctrl_fsm (
    input  logic                      CLK,
    input  logic                      nRST,
    input  l1_cache_pkg::proc_req_t   proc_req,
    input  logic                      mem_busy,
    input  logic                      hit,
    input  logic                      pass_through,
    input  logic                      victim_dirty,
    input  logic                      flush_valid,
    input  logic                      flush_dirty,
    input  logic                      word_done,
    input  logic                      set_done,
    input  logic                      flush,
    output l1_cache_pkg::array_cmd_t  array_cmd,
    output l1_cache_pkg::port_mode_t  port_mode,
    output logic                      word_en,
    output logic                      word_clr,
    output logic                      set_en,
    output logic                      set_clr,
    output logic                      busy,
    output logic                      flush_done
);
    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FETCH,
        FLUSH_SCAN,
        FLUSH_LINE
    } state_t;

    state_t state, next_state;
    logic   req;

    assign req = proc_req.ren || proc_req.wen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        array_cmd  = '0;
        port_mode  = l1_cache_pkg::NONE;
        word_en    = 1'b0;
        word_clr   = 1'b0;
        set_en     = 1'b0;
        set_clr    = 1'b0;
        busy       = 1'b1;  // processor waits unless told otherwise
        flush_done = 1'b0;

        case (state)
            IDLE: begin
                word_clr = 1'b1;  // also latches the line base
                set_clr  = 1'b1;
                if (req) begin
                    if (pass_through) begin
                        port_mode = l1_cache_pkg::PASS;
                        busy      = mem_busy;  // ends with the memory beat
                    end else if (hit) begin
                        busy                = 1'b0;
                        array_cmd.write_hit = proc_req.wen;
                    end else if (victim_dirty) begin
                        next_state = WRITEBACK;
                    end else begin
                        next_state = FETCH;
                    end
                end else if (flush) begin
                    next_state = FLUSH_SCAN;  // only with the bus quiet
                end
            end

            WRITEBACK: begin
                port_mode = l1_cache_pkg::WRITEBACK;
                if (word_done) begin
                    array_cmd.clean_line = 1'b1;
                    word_clr             = 1'b1;
                    next_state           = FETCH;
                end else begin
                    word_en = !mem_busy;
                end
            end

            FETCH: begin
                port_mode = l1_cache_pkg::FETCH;
                if (word_done) begin
                    array_cmd.fill_done = 1'b1;  // extra cycle for valid and tag
                    word_clr            = 1'b1;
                    next_state          = IDLE;  // request then completes as a hit
                end else if (!mem_busy) begin
                    word_en             = 1'b1;
                    array_cmd.fill_word = 1'b1;
                end
            end

            FLUSH_SCAN: begin
                if (set_done) begin
                    flush_done = 1'b1;
                    next_state = IDLE;
                end else if (flush_valid && flush_dirty) begin
                    next_state = FLUSH_LINE;
                end else begin
                    // clean or empty, drop it and move on
                    array_cmd.flush_inval = flush_valid;
                    set_en                = 1'b1;
                end
            end

            FLUSH_LINE: begin
                port_mode = l1_cache_pkg::FLUSH_WB;
                if (word_done) begin
                    array_cmd.flush_inval = 1'b1;
                    word_clr              = 1'b1;
                    set_en                = 1'b1;
                    next_state            = FLUSH_SCAN;
                end else begin
                    word_en = !mem_busy;
                end
            end

            default: next_state = IDLE;
        endcase
    end

endmodule

/* src/l1_cache.sv */
// **************************************************
// L1 data cache top, direct mapped, write back and
// write allocate; sits between the processor bus and
// the memory bus, flush writes back all dirty lines
// set CACHE_SIZE (bytes), BLOCK_SIZE (words, max 8)
// and NONCACHE_START_ADDR at the instance
// **************************************************
`timescale 1ns/100ps

module l1_cache #(
    parameter int                  CACHE_SIZE          = 256,
    parameter int                  BLOCK_SIZE          = 2,
    parameter l1_cache_pkg::word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::proc_req_t proc_req,
    output l1_cache_pkg::proc_rsp_t proc_rsp,
    output l1_cache_pkg::mem_req_t  mem_req,
    input  l1_cache_pkg::mem_rsp_t  mem_rsp,
    input  logic                   flush,
    output logic                   flush_done
);
    import l1_cache_pkg::*;

    localparam int N_SETS   = CACHE_SIZE / (BLOCK_SIZE * WORD_SIZE / 8);
    localparam int TAG_BITS = WORD_SIZE - $clog2(N_SETS) - $clog2(BLOCK_SIZE) - 2;
    localparam int WCNT_W   = $clog2(BLOCK_SIZE + 1);
    localparam int SCNT_W   = $clog2(N_SETS + 1);

    // array status
    logic                hit, pass_through, victim_dirty;
    logic                flush_valid, flush_dirty;
    logic [TAG_BITS-1:0] victim_tag, flush_tag;
    word_t               hit_rdata, line_rdata;

    // fsm controls
    array_cmd_t  array_cmd;
    port_mode_t  port_mode;
    logic        word_en, word_clr, set_en, set_clr;
    logic        proc_busy;

    // counters
    logic [WCNT_W-1:0] word_cnt;
    logic [SCNT_W-1:0] set_cnt;
    logic              word_done, set_done;

    cache_ctrl_fsm ctrl_inst (
        .CLK(CLK), .nRST(nRST),
        .proc_req(proc_req), .mem_busy(mem_rsp.busy),
        .hit(hit), .pass_through(pass_through), .victim_dirty(victim_dirty),
        .flush_valid(flush_valid), .flush_dirty(flush_dirty),
        .word_done(word_done), .set_done(set_done), .flush(flush),
        .array_cmd(array_cmd), .port_mode(port_mode),
        .word_en(word_en), .word_clr(word_clr), .set_en(set_en), .set_clr(set_clr),
        .busy(proc_busy), .flush_done(flush_done)
    );

    // words within a line
    block_counter #(.LIMIT(BLOCK_SIZE)) word_ctr (
        .CLK(CLK), .nRST(nRST), .clear(word_clr), .enable(word_en),
        .count(word_cnt), .done(word_done)
    );

    // sets walked by flush
    block_counter #(.LIMIT(N_SETS)) set_ctr (
        .CLK(CLK), .nRST(nRST), .clear(set_clr), .enable(set_en),
        .count(set_cnt), .done(set_done)
    );

    cache_frame_array #(
        .CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) array_inst (
        .CLK(CLK), .nRST(nRST),
        .proc_req(proc_req), .mem_rdata(mem_rsp.rdata), .array_cmd(array_cmd),
        .word_idx(word_cnt), .flush_set(set_cnt),
        .hit(hit), .pass_through(pass_through), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .hit_rdata(hit_rdata),
        .flush_valid(flush_valid), .flush_dirty(flush_dirty), .flush_tag(flush_tag),
        .line_rdata(line_rdata)
    );

    // base address is taken whenever the word counter restarts
    mem_access_port #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) port_inst (
        .CLK(CLK), .nRST(nRST),
        .proc_req(proc_req), .port_mode(port_mode), .capture(word_clr),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .flush_tag(flush_tag), .flush_set(set_cnt), .word_idx(word_cnt),
        .line_rdata(line_rdata), .hit_rdata(hit_rdata), .hit(hit),
        .busy(proc_busy), .mem_rsp(mem_rsp),
        .mem_req(mem_req), .proc_rsp(proc_rsp)
    );

endmodule

/* tb/tb_mem_model.sv */
// **************************************************
// behavioural word memory for the cache testbench
// unwritten words read as address ^ 32'h5A5A_C3C3,
// busy drops after 0 to 2 random wait cycles and
// every accepted beat lands in an ordered log
// **************************************************
`timescale 1ns/100ps

module tb_mem_model (
    input  logic                   CLK,
    input  l1_cache_pkg::mem_req_t req,
    output l1_cache_pkg::mem_rsp_t rsp
);
    import l1_cache_pkg::*;

    localparam int LOG_DEPTH = 1024;

    // accepted beats in order, reads and writes mixed
    logic  log_wr   [LOG_DEPTH];
    word_t log_addr [LOG_DEPTH];
    word_t log_data [LOG_DEPTH];  // bus wdata, or rdata handed out
    word_t log_word [LOG_DEPTH];  // memory word after the beat
    int    log_cnt;

    integer seed;
    int     wait_left;  // stall cycles before the next accept
    logic   busy_q;
    word_t  rdata_q;
    word_t  merged;

    // latest write wins, pattern otherwise
    function automatic word_t peek(input word_t addr);
        word_t a;
        word_t val;
        a   = {addr[31:2], 2'b00};
        val = a ^ 32'h5A5A_C3C3;
        for (int i = 0; i < log_cnt; i++) begin
            if (log_wr[i] && log_addr[i] == a) begin
                val = log_word[i];
            end
        end
        return val;
    endfunction

    initial begin
        seed      = 32'h7423;
        wait_left = 0;
        busy_q    = 1'b0;
        rdata_q   = '0;
        log_cnt   = 0;
    end

    always_comb begin
        rsp.busy  = busy_q;
        rsp.rdata = rdata_q;
    end

    // read data follows the address and any new write
    always @(req or log_cnt) begin
        rdata_q = peek(req.addr);
    end

    always @(posedge CLK) begin
        if (req.ren || req.wen) begin
            if (!busy_q) begin
                merged = peek(req.addr);
                for (int b = 0; b < 4; b++) begin
                    if (req.wen && req.byte_en[b]) begin
                        merged[8*b +: 8] = req.wdata[8*b +: 8];
                    end
                end
                log_wr[log_cnt]   = req.wen;
                log_addr[log_cnt] = {req.addr[31:2], 2'b00};
                log_data[log_cnt] = req.wen ? req.wdata : rdata_q;
                log_word[log_cnt] = merged;
                log_cnt           = log_cnt + 1;
                wait_left         = $unsigned($random(seed)) % 3;  // next stall
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(negedge CLK) begin
        busy_q <= (wait_left != 0);  // responses move on the falling edge
    end

endmodule

/* tb/tb_l1_cache.sv */
// **************************************************
// directed testbench for the L1 data cache
// runs reset, miss and hit, byte lane writes, dirty
// conflict, uncached access and flush against a
// behavioural memory; stops at the first mismatch
// **************************************************
`timescale 1ns/100ps

module tb_l1_cache;
    import l1_cache_pkg::*;

    localparam int    CACHE_SIZE  = 256;
    localparam int    BLOCK_SIZE  = 2;
    localparam word_t NONCACHE    = 32'h8000_0000;
    localparam int    N_SETS      = CACHE_SIZE / (BLOCK_SIZE * 4);
    localparam int    PERIOD      = 40;
    localparam int    N_TESTS     = 6;
    localparam int    FLUSH_WORST = N_SETS * (2 + 3 * BLOCK_SIZE) + 2;  // all dirty, max stalls
    localparam int    WAIT_LIMIT  = 2 * FLUSH_WORST;
    localparam int    WATCHDOG_NS = N_TESTS * WAIT_LIMIT * PERIOD;

    localparam word_t ADDR_A  = 32'h0000_1234;  // set 6, word 1
    localparam word_t ADDR_A0 = 32'h0000_1230;  // word 0 of the same line
    localparam word_t ADDR_B  = 32'h0000_5634;  // set 6, other tag
    localparam word_t ADDR_P  = 32'h8000_0040;  // uncached

    logic      CLK, nRST;
    proc_req_t proc_req;
    proc_rsp_t proc_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;
    logic      flush, flush_done;
    word_t     a_value, a0_value;  // expected contents of line A

    l1_cache #(
        .CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .NONCACHE_START_ADDR(NONCACHE)
    ) l1_cache_inst (
        .CLK(CLK), .nRST(nRST), .proc_req(proc_req), .proc_rsp(proc_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp), .flush(flush), .flush_done(flush_done)
    );

    tb_mem_model mem_inst (.CLK(CLK), .req(mem_req), .rsp(mem_rsp));

    initial CLK = 1'b0;
    always #(PERIOD/2) CLK = ~CLK;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp)
        else stop_run($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    function automatic word_t fill_pattern(input word_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t data, input byte_en_t be);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // one logged memory beat against kind, address and data
    task automatic check_beat(input int idx, input logic wr, input word_t addr, input word_t data);
        check_value("mem_req.wen", 32'(mem_inst.log_wr[idx]), 32'(wr));
        check_value("mem_req.addr", mem_inst.log_addr[idx], addr);
        check_value(wr ? "mem_req.wdata" : "mem_rsp.rdata", mem_inst.log_data[idx], data);
    endtask

    // drive on the falling edge, sample a quarter period before the rising edge
    task automatic access_cache(input logic rd, input logic wr, input word_t addr,
                                input word_t wdata, input byte_en_t be,
                                output word_t rdata, output int waited);
        waited = 0;
        @(negedge CLK);
        proc_req.ren     = rd;
        proc_req.wen     = wr;
        proc_req.addr    = addr;
        proc_req.wdata   = wdata;
        proc_req.byte_en = be;
        #(PERIOD/4);
        while (proc_rsp.busy !== 1'b0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run($sformatf("access to %h never completed, busy stayed high", addr));
            end
            @(negedge CLK);
            #(PERIOD/4);
        end
        rdata = proc_rsp.rdata;
        @(negedge CLK);  // completing edge is past
        proc_req = '0;
    endtask

    task automatic read_expect(input word_t addr, input word_t exp);
        word_t got;
        int    waited;
        access_cache(1'b1, 1'b0, addr, '0, '0, got, waited);
        check_value("proc_rsp.rdata", got, exp);
    endtask

    task automatic write_word(input word_t addr, input word_t data, input byte_en_t be);
        word_t unused;
        int    waited;
        access_cache(1'b0, 1'b1, addr, data, be, unused, waited);
    endtask

    task automatic write_and_read_back(input word_t data, input byte_en_t be);
        write_word(ADDR_A, data, be);
        a_value = merge_lanes(a_value, data, be);  // only enabled lanes move
        read_expect(ADDR_A, a_value);
    endtask

    task automatic pulse_flush(output int pulses);
        int cycles;
        pulses = 0;
        cycles = 0;
        @(negedge CLK);
        flush = 1'b1;  // IDLE picks it up at the next edge
        @(negedge CLK);
        flush = 1'b0;
        #(PERIOD/4);
        while (flush_done !== 1'b1) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_run("flush never finished, no flush_done seen");
            end
            @(negedge CLK);
            #(PERIOD/4);
        end
        // count this pulse and watch for a second one
        for (int i = 0; i < 2 * BLOCK_SIZE + 4; i++) begin
            if (flush_done === 1'b1) begin
                pulses++;
            end
            @(negedge CLK);
            #(PERIOD/4);
        end
    endtask

    task automatic check_reset_state();
        @(negedge CLK);
        #(PERIOD/4);
        check_value("mem_req.ren", mem_req.ren, 32'd0);
        check_value("mem_req.wen", mem_req.wen, 32'd0);
        check_value("flush_done", flush_done, 32'd0);
        check_value("proc_rsp.busy", proc_rsp.busy, 32'd1);  // idle with no request
    endtask

    task automatic read_miss_then_hit();
        int    mark;
        int    waited;
        word_t got;
        mark = mem_inst.log_cnt;
        read_expect(ADDR_A, fill_pattern(ADDR_A));
        check_value("refill beats", mem_inst.log_cnt - mark, BLOCK_SIZE);
        check_beat(mark, 1'b0, ADDR_A0, fill_pattern(ADDR_A0));
        check_beat(mark + 1, 1'b0, ADDR_A, fill_pattern(ADDR_A));
        mark = mem_inst.log_cnt;
        access_cache(1'b1, 1'b0, ADDR_A, '0, '0, got, waited);
        check_value("proc_rsp.rdata", got, fill_pattern(ADDR_A));
        check_value("hit wait cycles", waited, 0);
        check_value("beats on hit", mem_inst.log_cnt - mark, 0);
        a_value  = fill_pattern(ADDR_A);
        a0_value = fill_pattern(ADDR_A0);
    endtask

    task automatic write_hit_byte_lanes();
        int mark;
        mark = mem_inst.log_cnt;
        write_and_read_back(32'hDEAD_BEEF, 4'b0001);
        write_and_read_back(32'h1122_3344, 4'b1100);
        write_and_read_back(32'hCAFE_F00D, 4'b1111);
        check_value("beats on write hits", mem_inst.log_cnt - mark, 0);
    endtask

    task automatic dirty_conflict_miss();
        int mark;
        a0_value = 32'h0BAD_F00D;
        write_word(ADDR_A0, a0_value, 4'b1111);
        mark = mem_inst.log_cnt;
        read_expect(ADDR_B, fill_pattern(ADDR_B));
        check_value("conflict miss beats", mem_inst.log_cnt - mark, 2 * BLOCK_SIZE);
        check_beat(mark, 1'b1, ADDR_A0, a0_value);  // victim out first
        check_beat(mark + 1, 1'b1, ADDR_A, a_value);
        check_beat(mark + 2, 1'b0, ADDR_B - 4, fill_pattern(ADDR_B - 4));
        check_beat(mark + 3, 1'b0, ADDR_B, fill_pattern(ADDR_B));
        mark = mem_inst.log_cnt;
        read_expect(ADDR_A, a_value);  // back from memory, B was clean
        read_expect(ADDR_A0, a0_value);
        check_value("refill beats", mem_inst.log_cnt - mark, BLOCK_SIZE);
    endtask

    task automatic uncached_pass_through();
        int    mark;
        word_t wdata;
        wdata = 32'hA1B2_C3D4;
        mark  = mem_inst.log_cnt;
        read_expect(ADDR_P, fill_pattern(ADDR_P));
        write_word(ADDR_P, wdata, 4'b0101);
        read_expect(ADDR_P, merge_lanes(fill_pattern(ADDR_P), wdata, 4'b0101));
        check_value("uncached beats", mem_inst.log_cnt - mark, 3);
        check_beat(mark, 1'b0, ADDR_P, fill_pattern(ADDR_P));
        check_beat(mark + 1, 1'b1, ADDR_P, merge_lanes('0, wdata, 4'b0101));  // lanes 1, 3 zero
        check_beat(mark + 2, 1'b0, ADDR_P, merge_lanes(fill_pattern(ADDR_P), wdata, 4'b0101));
    endtask

    task automatic flush_all_lines();
        int    mark;
        int    pulses;
        word_t c2_word;
        write_word(32'h0000_2008, 32'h1357_9BDF, 4'b1111);  // set 1 word 0
        write_word(32'h0000_3050, 32'h2468_ACE0, 4'b0110);  // set 10 word 0
        write_word(32'h0000_40FC, 32'hFEDC_BA98, 4'b1111);  // set 31 word 1
        c2_word = merge_lanes(fill_pattern(32'h0000_3050), 32'h2468_ACE0, 4'b0110);
        mark    = mem_inst.log_cnt;
        pulse_flush(pulses);
        check_value("flush_done pulses", pulses, 1);
        check_value("flush beats", mem_inst.log_cnt - mark, 3 * BLOCK_SIZE);
        // ascending sets, line A is clean so no beats for set 6
        check_beat(mark, 1'b1, 32'h0000_2008, 32'h1357_9BDF);
        check_beat(mark + 1, 1'b1, 32'h0000_200C, fill_pattern(32'h0000_200C));
        check_beat(mark + 2, 1'b1, 32'h0000_3050, c2_word);
        check_beat(mark + 3, 1'b1, 32'h0000_3054, fill_pattern(32'h0000_3054));
        check_beat(mark + 4, 1'b1, 32'h0000_40F8, fill_pattern(32'h0000_40F8));
        check_beat(mark + 5, 1'b1, 32'h0000_40FC, 32'hFEDC_BA98);
        mark = mem_inst.log_cnt;
        read_expect(ADDR_A, a_value);  // invalidated, so refetched
        check_value("refill beats after flush", mem_inst.log_cnt - mark, BLOCK_SIZE);
        check_beat(mark, 1'b0, ADDR_A0, a0_value);
        check_beat(mark + 1, 1'b0, ADDR_A, a_value);
        read_expect(32'h0000_2008, 32'h1357_9BDF);
    endtask

    task automatic apply_reset();
        nRST     = 1'b0;
        proc_req = '0;
        flush    = 1'b0;
        repeat (3) @(negedge CLK);
        nRST = 1'b1;
    endtask

    initial begin
        apply_reset();
        check_reset_state();
        read_miss_then_hit();
        write_hit_byte_lanes();
        dirty_conflict_miss();
        uncached_pass_through();
        flush_all_lines();
        $display("test passed");
        $finish;
    end

    // hard stop if a wait loop slips through
    initial begin
        #(WATCHDOG_NS);
        stop_run("watchdog timeout, the tests did not finish in time");
    end

endmodule

/* project.f */
src/l1_cache_pkg.sv
src/block_counter.sv
src/cache_frame_array.sv
src/mem_access_port.sv
src/cache_ctrl_fsm.sv
src/l1_cache.sv
tb/tb_mem_model.sv
tb/tb_l1_cache.sv

/* Bender.yml */
package:
  name: l1_cache

sources:
  - src/l1_cache_pkg.sv
  - src/block_counter.sv
  - src/cache_frame_array.sv
  - src/mem_access_port.sv
  - src/cache_ctrl_fsm.sv
  - src/l1_cache.sv
  - target: test
    files:
      - tb/tb_mem_model.sv
      - tb/tb_l1_cache.sv
